/* source/arb_read_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface arb_read_if;

  // request, held by the arbiter for the whole burst
  axi_rd_pkg::addr_t      addr;
  axi_rd_pkg::burst_len_t len;
  axi_rd_pkg::beat_size_t size;
  axi_rd_pkg::axi_id_t    id;
  logic                   req_valid;

  // returned beats, one pulse per beat
  axi_rd_pkg::data_t      beat_data;
  logic                   beat_valid;
  logic                   beat_last;

  modport arb (
    output addr, len, size, id, req_valid,
    input  beat_data, beat_valid, beat_last
  );

  modport master (
    input  addr, len, size, id, req_valid,
    output beat_data, beat_valid, beat_last
  );

endinterface

`default_nettype wire

/* source/axi_rd_pkg.sv */
`default_nettype none

package axi_rd_pkg;

  // rv32 memory bus, widths are fixed
  typedef logic [31:0] addr_t;      // byte address
  typedef logic [31:0] data_t;      // one beat
  typedef logic [7:0]  burst_len_t; // beats minus one
  typedef logic [2:0]  beat_size_t; // axi size code
  typedef logic [3:0]  axi_id_t;

  // burst type code for AR
  localparam logic [1:0] BURST_INCR = 2'b01;

  // id per requester, echoed back on R
  localparam axi_id_t ID_FETCH = 4'd0;
  localparam axi_id_t ID_LOAD  = 4'd1;

  // read master states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0, // waiting for a granted request
    ST_ADDR = 2'd1, // AR presented
    ST_DATA = 2'd2, // collecting R beats
    ST_GAP  = 2'd3  // lets requester and arbiter drop the request
  } rd_state_e;

endpackage

`default_nettype wire

/* source/axi_read_master.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_read_master (
  input  wire                     clk,
  input  wire                     rst_n_i,
  // AR channel
  input  wire                     arready_i,
  output logic                    arvalid_o,
  output axi_rd_pkg::addr_t       araddr_o,
  output axi_rd_pkg::axi_id_t     arid_o,
  output axi_rd_pkg::burst_len_t  arlen_o,
  output axi_rd_pkg::beat_size_t  arsize_o,
  output logic [1:0]              arburst_o,
  // R channel
  input  wire                     rvalid_i,
  input  wire axi_rd_pkg::data_t  rdata_i,
  input  wire                     rlast_i,
  input  wire axi_rd_pkg::axi_id_t rid_i,
  output logic                    rready_o,
  // granted request from the arbiter
  arb_read_if.master              bus
);

  axi_rd_pkg::rd_state_e state_q;
  axi_rd_pkg::rd_state_e state_d;
  logic                  r_hs; // R handshake this cycle
  logic                  start;

  assign start = (state_q == axi_rd_pkg::ST_IDLE) && bus.req_valid;
  assign r_hs  = rvalid_i && rready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      axi_rd_pkg::ST_IDLE: begin
        if (bus.req_valid) begin
          state_d = axi_rd_pkg::ST_ADDR;
        end
      end
      axi_rd_pkg::ST_ADDR: begin
        if (arready_i) begin
          state_d = axi_rd_pkg::ST_DATA;
        end
      end
      axi_rd_pkg::ST_DATA: begin
        if (r_hs && rlast_i) begin
          state_d = axi_rd_pkg::ST_GAP;
        end
      end
      // one idle cycle, req_valid is gone by then
      axi_rd_pkg::ST_GAP: state_d = axi_rd_pkg::ST_IDLE;
      default: state_d = axi_rd_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= axi_rd_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // AR fields latched once per burst, unchanged while waiting for arready
  always_ff @(posedge clk) begin
    if (start) begin
      araddr_o <= bus.addr;
      arlen_o  <= bus.len;
      arsize_o <= bus.size;
      arid_o   <= bus.id;
    end
  end

  assign arvalid_o = (state_q == axi_rd_pkg::ST_ADDR);
  assign arburst_o = axi_rd_pkg::BURST_INCR;
  assign rready_o  = (state_q == axi_rd_pkg::ST_DATA); // always ready in data phase

  // beat strobes, one cycle behind the handshake
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bus.beat_valid <= 1'b0;
      bus.beat_last  <= 1'b0;
    end else begin
      bus.beat_valid <= r_hs;
      bus.beat_last  <= r_hs & rlast_i;
    end
  end

  always_ff @(posedge clk) begin
    if (r_hs) begin
      bus.beat_data <= rdata_i;
    end
  end

  a_ar_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    arvalid_o && !arready_i |=>
      arvalid_o && $stable(araddr_o) && $stable(arlen_o)
      && $stable(arsize_o) && $stable(arid_o)
  );

  // slave must answer with the id we issued
  a_rid_match: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    r_hs |-> rid_i == arid_o
  );

endmodule

`default_nettype wire

/* source/mem_bus_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_bus_top #(
  parameter bit LOAD_FIRST = 1'b1
) (
  input  wire                         clk,
  input  wire                         rst_n_i,
  // fetch refill port
  input  wire                         if_raddr_valid_i,
  input  wire axi_rd_pkg::addr_t      if_raddr_i,
  input  wire axi_rd_pkg::burst_len_t if_rlen_i,
  input  wire axi_rd_pkg::beat_size_t if_rsize_i,
  output axi_rd_pkg::data_t           if_rdata_o,
  output logic                        if_rdata_ready_o,
  output logic                        if_rlast_o,
  // load refill port
  input  wire                         mem_raddr_valid_i,
  input  wire axi_rd_pkg::addr_t      mem_raddr_i,
  input  wire axi_rd_pkg::burst_len_t mem_rlen_i,
  input  wire axi_rd_pkg::beat_size_t mem_rsize_i,
  output axi_rd_pkg::data_t           mem_rdata_o,
  output logic                        mem_rdata_ready_o,
  output logic                        mem_rlast_o,
  // AXI4 read address
  input  wire                         arready_i,
  output logic                        arvalid_o,
  output axi_rd_pkg::addr_t           araddr_o,
  output axi_rd_pkg::axi_id_t         arid_o,
  output axi_rd_pkg::burst_len_t      arlen_o,
  output axi_rd_pkg::beat_size_t      arsize_o,
  output logic [1:0]                  arburst_o,
  // AXI4 read data
  output logic                        rready_o,
  input  wire                         rvalid_i,
  input  wire axi_rd_pkg::data_t      rdata_i,
  input  wire                         rlast_i,
  input  wire axi_rd_pkg::axi_id_t    rid_i
);

  arb_read_if u_arb_bus ();

  read_arbiter #(
    .LOAD_FIRST(LOAD_FIRST)
  ) u_read_arbiter (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .if_raddr_valid_i (if_raddr_valid_i),
    .if_raddr_i       (if_raddr_i),
    .if_rlen_i        (if_rlen_i),
    .if_rsize_i       (if_rsize_i),
    .if_rdata_o       (if_rdata_o),
    .if_rdata_ready_o (if_rdata_ready_o),
    .if_rlast_o       (if_rlast_o),
    .mem_raddr_valid_i(mem_raddr_valid_i),
    .mem_raddr_i      (mem_raddr_i),
    .mem_rlen_i       (mem_rlen_i),
    .mem_rsize_i      (mem_rsize_i),
    .mem_rdata_o      (mem_rdata_o),
    .mem_rdata_ready_o(mem_rdata_ready_o),
    .mem_rlast_o      (mem_rlast_o),
    .bus              (u_arb_bus.arb)
  );

  axi_read_master u_axi_read_master (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .arready_i(arready_i),
    .arvalid_o(arvalid_o),
    .araddr_o (araddr_o),
    .arid_o   (arid_o),
    .arlen_o  (arlen_o),
    .arsize_o (arsize_o),
    .arburst_o(arburst_o),
    .rvalid_i (rvalid_i),
    .rdata_i  (rdata_i),
    .rlast_i  (rlast_i),
    .rid_i    (rid_i),
    .rready_o (rready_o),
    .bus      (u_arb_bus.master)
  );

endmodule

`default_nettype wire

/* source/read_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module read_arbiter #(
  parameter bit LOAD_FIRST = 1'b1 // load wins a tie
) (
  input  wire                         clk,
  input  wire                         rst_n_i,
  // fetch refill requester
  input  wire                         if_raddr_valid_i,
  input  wire axi_rd_pkg::addr_t      if_raddr_i,
  input  wire axi_rd_pkg::burst_len_t if_rlen_i,
  input  wire axi_rd_pkg::beat_size_t if_rsize_i,
  output axi_rd_pkg::data_t           if_rdata_o,
  output logic                        if_rdata_ready_o,
  output logic                        if_rlast_o,
  // load refill requester
  input  wire                         mem_raddr_valid_i,
  input  wire axi_rd_pkg::addr_t      mem_raddr_i,
  input  wire axi_rd_pkg::burst_len_t mem_rlen_i,
  input  wire axi_rd_pkg::beat_size_t mem_rsize_i,
  output axi_rd_pkg::data_t           mem_rdata_o,
  output logic                        mem_rdata_ready_o,
  output logic                        mem_rlast_o,
  // towards the read master
  arb_read_if.arb                     bus
);

  logic grant_valid; // a burst owns the bus
  logic grant_load;  // 1 = load, 0 = fetch
  logic pick_load;

  // winner when both ask in the same cycle
  assign pick_load = mem_raddr_valid_i & (LOAD_FIRST | ~if_raddr_valid_i);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      grant_valid <= 1'b0;
      grant_load  <= 1'b0;
    end else if (grant_valid) begin
      if (bus.beat_last) begin
        grant_valid <= 1'b0; // free again the cycle after the last beat
      end
    end else if (if_raddr_valid_i || mem_raddr_valid_i) begin
      grant_valid <= 1'b1;
      grant_load  <= pick_load;
    end
  end

  // request fields come straight from the owner, which holds them stable
  assign bus.req_valid = grant_valid;
  assign bus.addr      = grant_load ? mem_raddr_i : if_raddr_i;
  assign bus.len       = grant_load ? mem_rlen_i : if_rlen_i;
  assign bus.size      = grant_load ? mem_rsize_i : if_rsize_i;
  assign bus.id        = grant_load ? axi_rd_pkg::ID_LOAD : axi_rd_pkg::ID_FETCH;

  // beats go back to the owner only
  assign if_rdata_o        = grant_load ? '0 : bus.beat_data;
  assign mem_rdata_o       = grant_load ? bus.beat_data : '0;
  assign if_rdata_ready_o  = bus.beat_valid & grant_valid & ~grant_load;
  assign mem_rdata_ready_o = bus.beat_valid & grant_valid & grant_load;
  assign if_rlast_o        = bus.beat_last & grant_valid & ~grant_load;
  assign mem_rlast_o       = bus.beat_last & grant_valid & grant_load;

  // owner and its request stay put until the master reports the last beat
  a_grant_held: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    bus.req_valid && !bus.beat_last |=>
      bus.req_valid && $stable(grant_load) && $stable(bus.addr) && $stable(bus.len)
  );

endmodule

`default_nettype wire

/* verification/tb_mem_bus_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_bus_top;

  localparam int CLK_PERIOD  = 4;
  localparam int NUM_RANDOM  = 20;
  localparam int NUM_DIRECT  = 5; // requests issued by the directed tests
  localparam int WATCHDOG_NS = (NUM_RANDOM + NUM_DIRECT) * 64 * CLK_PERIOD;

  logic                   clk;
  logic                   rst_n_i;
  logic                   if_raddr_valid_i;
  axi_rd_pkg::addr_t      if_raddr_i;
  axi_rd_pkg::burst_len_t if_rlen_i;
  axi_rd_pkg::beat_size_t if_rsize_i;
  axi_rd_pkg::data_t      if_rdata_o;
  logic                   if_rdata_ready_o;
  logic                   if_rlast_o;
  logic                   mem_raddr_valid_i;
  axi_rd_pkg::addr_t      mem_raddr_i;
  axi_rd_pkg::burst_len_t mem_rlen_i;
  axi_rd_pkg::beat_size_t mem_rsize_i;
  axi_rd_pkg::data_t      mem_rdata_o;
  logic                   mem_rdata_ready_o;
  logic                   mem_rlast_o;
  logic                   arready_i;
  logic                   arvalid_o;
  axi_rd_pkg::addr_t      araddr_o;
  axi_rd_pkg::axi_id_t    arid_o;
  axi_rd_pkg::burst_len_t arlen_o;
  axi_rd_pkg::beat_size_t arsize_o;
  logic [1:0]             arburst_o;
  logic                   rready_o;
  logic                   rvalid_i;
  axi_rd_pkg::data_t      rdata_i;
  logic                   rlast_i;
  axi_rd_pkg::axi_id_t    rid_i;

  string                  test_name;
  int unsigned            cyc = 0;
  logic                   slow_ar;    // force the longest arready delay
  axi_rd_pkg::burst_len_t if_beat;    // beats seen in the current burst
  axi_rd_pkg::burst_len_t mem_beat;
  logic                   r_hs_d;     // R handshake one cycle ago
  logic [48:0]            exp_ar;
  logic [48:0]            act_ar;
  logic [48:0]            ar_prev;
  logic [34:0]            exp_if_beat;
  logic [34:0]            act_if_beat;
  logic [34:0]            exp_mem_beat;
  logic [34:0]            act_mem_beat;
  logic [5:0]             idle_outs;
  logic                   any_valid;
  logic                   beat_pulse;

  mem_bus_top u_mem_bus_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // load wins whenever it is requesting, burst is always INCR
  assign exp_ar = mem_raddr_valid_i
                ? {axi_rd_pkg::ID_LOAD, mem_rlen_i, mem_rsize_i, 2'b01, mem_raddr_i}
                : {axi_rd_pkg::ID_FETCH, if_rlen_i, if_rsize_i, 2'b01, if_raddr_i};
  assign act_ar = {arid_o, arlen_o, arsize_o, arburst_o, araddr_o};

  // owner flag, pulse, last flag, data
  assign exp_if_beat  = {2'b11, if_beat == if_rlen_i,
                         (if_raddr_i + {if_beat, 2'b00}) ^ 32'hA5A5_0000};
  assign act_if_beat  = {if_raddr_valid_i & ~mem_raddr_valid_i, if_rdata_ready_o,
                         if_rlast_o, if_rdata_o};
  assign exp_mem_beat = {2'b11, mem_beat == mem_rlen_i,
                         (mem_raddr_i + {mem_beat, 2'b00}) ^ 32'hA5A5_0000};
  assign act_mem_beat = {mem_raddr_valid_i, mem_rdata_ready_o, mem_rlast_o, mem_rdata_o};

  assign idle_outs  = {arvalid_o, rready_o, if_rdata_ready_o, if_rlast_o,
                       mem_rdata_ready_o, mem_rlast_o};
  assign any_valid  = if_raddr_valid_i | mem_raddr_valid_i;
  assign beat_pulse = if_rdata_ready_o | mem_rdata_ready_o;

  always @(posedge clk) begin
    cyc     <= cyc + 1;
    ar_prev <= act_ar;
    r_hs_d  <= rvalid_i & rready_o;
    if (!rst_n_i || if_rlast_o) begin
      if_beat <= '0;
    end else if (if_rdata_ready_o) begin
      if_beat <= if_beat + 1'b1;
    end
    if (!rst_n_i || mem_rlast_o) begin
      mem_beat <= '0;
    end else if (mem_rdata_ready_o) begin
      mem_beat <= mem_beat + 1'b1;
    end
  end

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
    $display(">>> FAIL");
    $fatal(1, "check on %s failed", what);
  endtask

  // edges 2 to 7, outputs settled by the first reset edge
  a_reset_idle: assert property (@(posedge clk) cyc >= 1 && cyc <= 6 |-> idle_outs === 6'b0)
    else report_mismatch("outputs low in reset", 64'd0, $sampled(idle_outs));

  a_ar_request: assert property (@(posedge clk) disable iff (!rst_n_i)
    arvalid_o && arready_i |-> act_ar == exp_ar)
    else report_mismatch("AR id/len/size/burst/addr", $sampled(exp_ar), $sampled(act_ar));

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    arvalid_o && !arready_i |=> {arvalid_o, act_ar} == {1'b1, ar_prev})
    else report_mismatch("AR held while stalled", $sampled({1'b1, ar_prev}),
                         $sampled({arvalid_o, act_ar}));

  a_ar_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(any_valid) |=> !arvalid_o ##1 arvalid_o)
    else report_mismatch("arvalid two cycles after request", 64'd1, $sampled(arvalid_o));

  a_beat_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    beat_pulse == r_hs_d)
    else report_mismatch("beat pulse after R handshake", $sampled(r_hs_d),
                         $sampled(beat_pulse));

  a_if_beat: assert property (@(posedge clk) disable iff (!rst_n_i)
    if_rdata_ready_o || if_rlast_o |-> act_if_beat == exp_if_beat)
    else report_mismatch("fetch beat", $sampled(exp_if_beat), $sampled(act_if_beat));

  a_mem_beat: assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_rdata_ready_o || mem_rlast_o |-> act_mem_beat == exp_mem_beat)
    else report_mismatch("load beat", $sampled(exp_mem_beat), $sampled(act_mem_beat));

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one refill: raise valid, hold until rlast, drop a cycle later
  task automatic run_request(input bit is_load, input axi_rd_pkg::addr_t addr,
                             input axi_rd_pkg::burst_len_t len);
    next_cycle();
    if (is_load) begin
      mem_raddr_i       = addr;
      mem_rlen_i        = len;
      mem_raddr_valid_i = 1'b1;
      do next_cycle(); while (mem_rlast_o !== 1'b1);
      next_cycle();
      mem_raddr_valid_i = 1'b0;
    end else begin
      if_raddr_i       = addr;
      if_rlen_i        = len;
      if_raddr_valid_i = 1'b1;
      do next_cycle(); while (if_rlast_o !== 1'b1);
      next_cycle();
      if_raddr_valid_i = 1'b0;
    end
  endtask

  // AXI slave, one burst at a time
  initial begin : slave_model
    axi_rd_pkg::addr_t      base;
    axi_rd_pkg::burst_len_t len;
    axi_rd_pkg::axi_id_t    id;
    logic [31:0]            rng;
    int                     wait_cyc;
    rng       = 32'd49;
    arready_i = 1'b0;
    rvalid_i  = 1'b0;
    rdata_i   = '0;
    rlast_i   = 1'b0;
    rid_i     = '0;
    wait (rst_n_i === 1'b1);
    forever begin
      do next_cycle(); while (arvalid_o !== 1'b1);
      base     = araddr_o;
      len      = arlen_o;
      id       = arid_o;
      rng      = xorshift32(rng);
      wait_cyc = slow_ar ? 3 : rng % 4;
      repeat (wait_cyc) next_cycle();
      arready_i = 1'b1;
      next_cycle();
      arready_i = 1'b0;
      for (int i = 0; i <= len; i++) begin
        rng = xorshift32(rng);
        repeat (rng % 3) next_cycle(); // gap with rvalid low
        rvalid_i = 1'b1;
        rdata_i  = (base + 4 * i) ^ 32'hA5A5_0000;
        rlast_i  = (i == len);
        rid_i    = id;
        next_cycle();
        rvalid_i = 1'b0;
        rlast_i  = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [31:0]       rng;
    axi_rd_pkg::addr_t addr;
    rng               = 32'd49;
    test_name         = "reset_idle";
    slow_ar           = 1'b0;
    rst_n_i           = 1'b0;
    if_raddr_valid_i  = 1'b0;
    if_raddr_i        = '0;
    if_rlen_i         = '0;
    if_rsize_i        = 3'd2; // word beats
    mem_raddr_valid_i = 1'b0;
    mem_raddr_i       = '0;
    mem_rlen_i        = '0;
    mem_rsize_i       = 3'd2;
    repeat (5) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    repeat (3) next_cycle();

    test_name = "single_fetch";
    run_request(1'b0, 32'h0000_1000, 8'd0);
    test_name = "load_burst";
    run_request(1'b1, 32'h0000_2040, 8'd3);

    test_name = "tie_priority";
    fork
      run_request(1'b1, 32'h0000_4100, 8'd1);
      run_request(1'b0, 32'h0000_5200, 8'd2);
    join

    test_name = "ar_backpressure";
    slow_ar   = 1'b1;
    run_request(1'b0, 32'h0000_3000, 8'd1);
    slow_ar = 1'b0;

    test_name = "random_mix";
    repeat (NUM_RANDOM) begin
      rng  = xorshift32(rng);
      addr = rng & 32'hFFFF_FFFC;
      rng  = xorshift32(rng);
      repeat (rng[9:8]) next_cycle();
      run_request(rng[4], addr, {5'd0, rng[2:0]});
    end

    repeat (4) next_cycle();
    $display(">>> PASS");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: requests did not complete within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* vlog.f */
source/axi_rd_pkg.sv
source/arb_read_if.sv
source/read_arbiter.sv
source/axi_read_master.sv
source/mem_bus_top.sv
verification/tb_mem_bus_top.sv
